// File: Makefile
VERILATOR ?= verilator
TOP       ?= flight_core_tb
FILELIST  ?= drone_flight.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: drone_flight.f
+incdir+logic
logic/flight_pkg.sv
logic/angle_stage.sv
logic/rate_stage.sv
logic/mixer_stage.sv
logic/motor_pwm.sv
logic/flight_core.sv
tests/flight_core_sva.sv
tests/flight_core_tb.sv

// File: logic/angle_stage.sv
// Angle stage: converts stick positions into target body rates, one cycle
`include "flight_settings.svh"

module angle_stage
    import flight_pkg::*;
(
    input  logic         sys_clk,
    input  logic         resetn,
    input  logic         in_valid,
    input  sample_t      in_sample,
    output logic         out_valid,
    output rate_target_t out_target
);

    localparam logic signed [15:0] NEUTRAL = 16'(`STICK_NEUTRAL);

    // Signed stick offsets from centre
    logic signed [15:0] roll_ofs;
    logic signed [15:0] pitch_ofs;
    logic signed [15:0] yaw_ofs;

    // Next target rates
    logic signed [15:0] roll_tgt;
    logic signed [15:0] pitch_tgt;
    logic signed [15:0] yaw_tgt;

    function automatic logic signed [15:0] stick_offset(input logic [7:0] stick);
        return $signed({8'd0, stick}) - NEUTRAL;
    endfunction

    always_comb begin
        roll_ofs  = stick_offset(in_sample.sticks.roll);
        pitch_ofs = stick_offset(in_sample.sticks.pitch);
        yaw_ofs   = stick_offset(in_sample.sticks.yaw);

        // Yaw never uses the angle loop
        yaw_tgt = yaw_ofs <<< `RATE_SHIFT;

        if (in_sample.mode == MODE_ANGLE) begin
            // Stick sets an angle, error against measured angle
            roll_tgt  = (roll_ofs <<< `ANGLE_SHIFT) - in_sample.attitude.roll_angle;
            pitch_tgt = (pitch_ofs <<< `ANGLE_SHIFT) - in_sample.attitude.pitch_angle;
        end else begin
            roll_tgt  = roll_ofs <<< `RATE_SHIFT;
            pitch_tgt = pitch_ofs <<< `RATE_SHIFT;
        end
    end

    // Strobe
    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // Payload, captured with the strobe
    always_ff @(posedge sys_clk) begin
        if (in_valid) begin
            out_target.throttle     <= in_sample.sticks.throttle;
            out_target.roll_target  <= roll_tgt;
            out_target.pitch_target <= pitch_tgt;
            out_target.yaw_target   <= yaw_tgt;
            // Measured rates go on to the rate stage
            out_target.roll_rate    <= in_sample.attitude.roll_rate;
            out_target.pitch_rate   <= in_sample.attitude.pitch_rate;
            out_target.yaw_rate     <= in_sample.attitude.yaw_rate;
        end
    end

endmodule

// File: logic/flight_core.sv
// Flight core: angle, rate and mixer stages chained into the motor PWM outputs
module flight_core
    import flight_pkg::*;
(
    input  logic       sys_clk,
    input  logic       resetn,
    input  logic       sample_valid,
    input  sample_t    sample,
    output logic       motor_valid,
    output motor_set_t motor,
    output logic [3:0] motor_pwm_out
);

    // Angle to rate link
    logic         target_valid;
    rate_target_t target;

    // Rate to mixer link
    logic      cmd_valid;
    axis_cmd_t cmd;

    // Sticks to target rates, 1 cycle
    angle_stage u_angle (
        .sys_clk    (sys_clk),
        .resetn     (resetn),
        .in_valid   (sample_valid),
        .in_sample  (sample),
        .out_valid  (target_valid),
        .out_target (target)
    );

    // Rate errors to corrections, 2 cycles
    rate_stage u_rate (
        .sys_clk   (sys_clk),
        .resetn    (resetn),
        .in_valid  (target_valid),
        .in_target (target),
        .out_valid (cmd_valid),
        .out_cmd   (cmd)
    );

    // Corrections to motor rates, 2 cycles
    mixer_stage u_mixer (
        .sys_clk   (sys_clk),
        .resetn    (resetn),
        .in_valid  (cmd_valid),
        .in_cmd    (cmd),
        .out_valid (motor_valid),
        .out_motor (motor)
    );

    // ESC drive
    motor_pwm u_pwm (
        .sys_clk    (sys_clk),
        .resetn     (resetn),
        .rate_valid (motor_valid),
        .rates      (motor),
        .pwm        (motor_pwm_out)
    );

endmodule

// File: logic/flight_pkg.sv
// Flight package: flight mode and the payload structs passed between pipeline stages
package flight_pkg;

    // Roll and pitch handling, yaw is always rate
    typedef enum logic {
        MODE_RATE  = 1'b0,
        MODE_ANGLE = 1'b1
    } flight_mode_e;

    // Raw receiver sticks, 0 to 255
    typedef struct packed {
        logic [7:0] throttle;
        logic [7:0] roll;
        logic [7:0] yaw;
        logic [7:0] pitch;
    } stick_set_t;

    // IMU attitude, angles and body rates
    typedef struct packed {
        logic signed [15:0] roll_angle;
        logic signed [15:0] pitch_angle;
        logic signed [15:0] roll_rate;
        logic signed [15:0] pitch_rate;
        logic signed [15:0] yaw_rate;
    } attitude_t;

    // One pipeline sample
    typedef struct packed {
        flight_mode_e mode;
        stick_set_t   sticks;
        attitude_t    attitude;
    } sample_t;

    // Angle stage to rate stage
    typedef struct packed {
        logic [7:0]         throttle;
        logic signed [15:0] roll_target;
        logic signed [15:0] pitch_target;
        logic signed [15:0] yaw_target;
        // Measured rates, carried along
        logic signed [15:0] roll_rate;
        logic signed [15:0] pitch_rate;
        logic signed [15:0] yaw_rate;
    } rate_target_t;

    // Rate stage to mixer
    typedef struct packed {
        logic [7:0]         throttle;
        logic signed [15:0] roll;
        logic signed [15:0] pitch;
        logic signed [15:0] yaw;
    } axis_cmd_t;

    // Mixer output, 0 to MOTOR_MAX per motor
    typedef struct packed {
        logic [7:0] motor_1;
        logic [7:0] motor_2;
        logic [7:0] motor_3;
        logic [7:0] motor_4;
    } motor_set_t;

endpackage

// File: logic/flight_settings.svh
// Flight settings: stick centre, controller gains, output limits and PWM timing
`ifndef FLIGHT_SETTINGS_SVH
`define FLIGHT_SETTINGS_SVH

// Receiver stick centre, sticks run 0 to 255
`define STICK_NEUTRAL 128

// Stick offset to target rate in rate mode
`define RATE_SHIFT 3
// Stick offset to target angle in angle mode
`define ANGLE_SHIFT 2

// Proportional gain as a right shift of the rate error
`define RATE_P_SHIFT 4
// Magnitude limit per axis correction
`define CORR_LIMIT 60

// Motor rate ceiling
`define MOTOR_MAX 250
// Below this throttle the motors stay off
`define ARM_THROTTLE 16

// sys_clk cycles per PWM tick
`define PWM_TICK_DIV 4
// Ticks in one PWM frame
`define PWM_FRAME_TICKS 256

`endif

// File: logic/mixer_stage.sv
// Mixer stage: quad-X motor mix with arming threshold and output clamp, two cycles
`include "flight_settings.svh"

module mixer_stage
    import flight_pkg::*;
(
    input  logic       sys_clk,
    input  logic       resetn,
    input  logic       in_valid,
    input  axis_cmd_t  in_cmd,
    output logic       out_valid,
    output motor_set_t out_motor
);

    localparam logic signed [15:0] MOTOR_TOP = 16'(`MOTOR_MAX);

    logic               mix_valid;
    logic               arm_q;
    // Raw signed motor sums, index 0 is motor 1
    logic signed [15:0] sum_q [4];
    logic signed [15:0] thr;

    // Keep a sum inside 0 to MOTOR_MAX
    function automatic logic [7:0] clamp_motor(input logic signed [15:0] sum);
        if (sum < 16'sd0) begin
            return 8'd0;
        end
        if (sum > MOTOR_TOP) begin
            return MOTOR_TOP[7:0];
        end
        return sum[7:0];
    endfunction

    assign thr = $signed({8'd0, in_cmd.throttle});

    // Cycle 1: mix and arm check
    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            mix_valid <= 1'b0;
        end else begin
            mix_valid <= in_valid;
        end
        if (in_valid) begin
            // Front left, front right, rear right, rear left
            sum_q[0] <= thr + in_cmd.roll + in_cmd.pitch - in_cmd.yaw;
            sum_q[1] <= thr - in_cmd.roll + in_cmd.pitch + in_cmd.yaw;
            sum_q[2] <= thr - in_cmd.roll - in_cmd.pitch - in_cmd.yaw;
            sum_q[3] <= thr + in_cmd.roll - in_cmd.pitch + in_cmd.yaw;
            arm_q    <= in_cmd.throttle >= 8'(`ARM_THROTTLE);
        end
    end

    // Cycle 2: clamp, or all off when disarmed
    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            out_valid <= 1'b0;
            out_motor <= '0;
        end else begin
            out_valid <= mix_valid;
            if (mix_valid) begin
                out_motor.motor_1 <= arm_q ? clamp_motor(sum_q[0]) : 8'd0;
                out_motor.motor_2 <= arm_q ? clamp_motor(sum_q[1]) : 8'd0;
                out_motor.motor_3 <= arm_q ? clamp_motor(sum_q[2]) : 8'd0;
                out_motor.motor_4 <= arm_q ? clamp_motor(sum_q[3]) : 8'd0;
            end
        end
    end

endmodule

// File: logic/motor_pwm.sv
// Motor PWM: four-channel frame-based PWM, new rates take effect at frame start
`include "flight_settings.svh"

module motor_pwm
    import flight_pkg::*;
(
    input  logic       sys_clk,
    input  logic       resetn,
    input  logic       rate_valid,
    input  motor_set_t rates,
    output logic [3:0] pwm
);

    localparam int DIV_W   = $clog2(`PWM_TICK_DIV);
    localparam int FRAME_W = $clog2(`PWM_FRAME_TICKS);

    // Cycle within tick, tick within frame
    logic [DIV_W-1:0]   div_cnt;
    logic [FRAME_W-1:0] frame_cnt;
    logic               tick_end;
    logic               frame_end;

    // Latest received set and the one driving this frame
    motor_set_t pending;
    motor_set_t active;

    assign tick_end  = div_cnt == DIV_W'(`PWM_TICK_DIV - 1);
    assign frame_end = tick_end && (frame_cnt == FRAME_W'(`PWM_FRAME_TICKS - 1));

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            div_cnt   <= '0;
            frame_cnt <= '0;
            pending   <= '0;
            active    <= '0;
        end else begin
            div_cnt <= tick_end ? '0 : div_cnt + 1'b1;
            if (tick_end) begin
                frame_cnt <= frame_cnt + 1'b1;
            end
            if (rate_valid) begin
                pending <= rates;
            end
            // A set arriving on the last cycle still makes the next frame
            if (frame_end) begin
                active <= rate_valid ? rates : pending;
            end
        end
    end

    // High for the first N ticks, bit 0 is motor 1
    assign pwm[0] = frame_cnt < active.motor_1;
    assign pwm[1] = frame_cnt < active.motor_2;
    assign pwm[2] = frame_cnt < active.motor_3;
    assign pwm[3] = frame_cnt < active.motor_4;

endmodule

// File: logic/rate_stage.sv
// Rate stage: proportional rate controller with per-axis saturation, two cycles
`include "flight_settings.svh"

module rate_stage
    import flight_pkg::*;
(
    input  logic         sys_clk,
    input  logic         resetn,
    input  logic         in_valid,
    input  rate_target_t in_target,
    output logic         out_valid,
    output axis_cmd_t    out_cmd
);

    // Correction bounds
    localparam logic signed [15:0] CORR_MAX = 16'(`CORR_LIMIT);
    localparam logic signed [15:0] CORR_MIN = -CORR_MAX;

    // First register, rate errors with throttle alongside
    logic      err_valid;
    axis_cmd_t err_q;

    // P term then clamp
    function automatic logic signed [15:0] sat_corr(input logic signed [15:0] err);
        logic signed [15:0] scaled;
        scaled = err >>> `RATE_P_SHIFT;
        if (scaled > CORR_MAX) begin
            return CORR_MAX;
        end
        if (scaled < CORR_MIN) begin
            return CORR_MIN;
        end
        return scaled;
    endfunction

    // Strobe pipe, two deep
    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            err_valid <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            err_valid <= in_valid;
            out_valid <= err_valid;
        end
    end

    // Cycle 1: target minus measured
    always_ff @(posedge sys_clk) begin
        if (in_valid) begin
            err_q.throttle <= in_target.throttle;
            err_q.roll     <= in_target.roll_target - in_target.roll_rate;
            err_q.pitch    <= in_target.pitch_target - in_target.pitch_rate;
            err_q.yaw      <= in_target.yaw_target - in_target.yaw_rate;
        end
    end

    // Cycle 2: scale and saturate
    always_ff @(posedge sys_clk) begin
        if (err_valid) begin
            out_cmd.throttle <= err_q.throttle;
            out_cmd.roll     <= sat_corr(err_q.roll);
            out_cmd.pitch    <= sat_corr(err_q.pitch);
            out_cmd.yaw      <= sat_corr(err_q.yaw);
        end
    end

endmodule

// File: tests/flight_core_sva.sv
// Flight core assertions: pipeline latency, reset state, motor range and idle PWM lines
`include "flight_settings.svh"

module flight_core_sva
    import flight_pkg::*;
(
    input logic       sys_clk,
    input logic       resetn,
    input logic       sample_valid,
    input logic       motor_valid,
    input motor_set_t motor,
    input logic [3:0] motor_pwm_out
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int FRAME_CYCLES = `PWM_FRAME_TICKS * `PWM_TICK_DIV;

    // Cycle within the PWM frame, frames start at reset release
    int         frame_pos;
    // Lines low in the first cycle of this frame, bit 0 is motor 1
    logic [3:0] idle_line;

    always_ff @(posedge sys_clk) begin
        if (!resetn) begin
            frame_pos <= 0;
            idle_line <= '0;
        end else begin
            frame_pos <= (frame_pos == FRAME_CYCLES - 1) ? 0 : frame_pos + 1;
            // Nonzero rate means high on the first tick
            if (frame_pos == 0) begin
                idle_line <= ~motor_pwm_out;
            end
        end
    end

    // Five stages of strobe, no gaps or extras
    latency_exact: assert property (@(posedge sys_clk) disable iff (!resetn)
        motor_valid == $past(sample_valid, 5))
        else $error("motor_valid not 5 cycles after sample_valid");

    // Quiet outputs during reset and right after it
    reset_quiet: assert property (@(posedge sys_clk)
        !resetn |=> !motor_valid && motor == '0 && motor_pwm_out == 4'b0)
        else $error("outputs active after a reset cycle");

    motor_range: assert property (@(posedge sys_clk) disable iff (!resetn)
        motor_valid |-> motor.motor_1 <= 8'(`MOTOR_MAX) && motor.motor_2 <= 8'(`MOTOR_MAX)
                     && motor.motor_3 <= 8'(`MOTOR_MAX) && motor.motor_4 <= 8'(`MOTOR_MAX))
        else $error("motor value above MOTOR_MAX");

    // Zero rate line stays low for the rest of its frame
    pwm_zero_low: assert property (@(posedge sys_clk) disable iff (!resetn)
        frame_pos != 0 |-> (motor_pwm_out & idle_line) == 4'b0)
        else $error("PWM line high in a frame whose rate is zero");

endmodule

bind flight_core flight_core_sva u_sva (
    .sys_clk       (sys_clk),
    .resetn        (resetn),
    .sample_valid  (sample_valid),
    .motor_valid   (motor_valid),
    .motor         (motor),
    .motor_pwm_out (motor_pwm_out)
);

// File: tests/flight_core_tb.sv
// Flight core testbench: random samples against a reference model plus a PWM frame check
`include "flight_settings.svh"

module flight_core_tb
    import flight_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    typedef enum int {KIND_RATE, KIND_ANGLE, KIND_SAT, KIND_DISARM, KIND_STREAM} sample_kind_e;

    localparam int FRAME_CYCLES = `PWM_FRAME_TICKS * `PWM_TICK_DIV;
    localparam int N_RATE = 20;
    localparam int N_ANGLE = 20;
    localparam int N_SAT = 12;
    localparam int N_DISARM = 10;
    localparam int N_STREAM = 40;
    // The PWM test adds one sample
    localparam int N_TOTAL = N_RATE + N_ANGLE + N_SAT + N_DISARM + N_STREAM + 1;
    localparam int WATCHDOG_CYCLES = N_TOTAL * 10 + 3 * FRAME_CYCLES + 100;

    logic        sys_clk;
    logic        resetn = 1'b0;
    logic        sample_valid = 1'b0;
    sample_t     sample = '0;
    logic        motor_valid;
    motor_set_t  motor;
    logic [3:0]  motor_pwm_out;

    logic [31:0] rng = 32'h7679_4c1d;
    int          cycle = 0;
    int          errors = 0;
    int          passed = 0;
    int          failed = 0;
    // Expected results and their sample cycles, in arrival order
    motor_set_t  exp_q [$];
    int          stamp_q [$];

    flight_core dut (
        .sys_clk       (sys_clk),
        .resetn        (resetn),
        .sample_valid  (sample_valid),
        .sample        (sample),
        .motor_valid   (motor_valid),
        .motor         (motor),
        .motor_pwm_out (motor_pwm_out)
    );

    initial begin
        sys_clk = 1'b0;
        forever #4 sys_clk = ~sys_clk;
    end

    always @(posedge sys_clk) cycle <= cycle + 1;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // Uniform in -span to span
    function automatic int rand_span(input int span);
        rng = xorshift32(rng);
        return int'(rng % (2 * span + 1)) - span;
    endfunction

    function automatic logic [7:0] rand_stick(input int span, input logic extreme);
        if (extreme) begin
            return (rand_span(1) >= 0) ? 8'd255 : 8'd0;
        end
        return 8'(`STICK_NEUTRAL + rand_span(span));
    endfunction

    function automatic sample_t make_sample(input sample_kind_e kind);
        sample_t s;
        logic    wild;
        int      stick_span;
        int      rate_span;
        wild       = (kind == KIND_SAT) || (kind == KIND_DISARM);
        stick_span = (kind == KIND_ANGLE) ? 10 : 127;
        rate_span  = wild ? 8000 : 2000;
        s.mode = (kind == KIND_ANGLE) ? MODE_ANGLE : MODE_RATE;
        if (kind == KIND_SAT || kind == KIND_STREAM) begin
            s.mode = flight_mode_e'(rand_span(1) > 0);
        end
        // Disarm keeps throttle in 0 to 14
        s.sticks.throttle = (kind == KIND_DISARM) ? 8'(7 + rand_span(7)) : rand_stick(100, 1'b0);
        s.sticks.roll  = rand_stick(stick_span, wild);
        s.sticks.pitch = rand_stick(stick_span, wild);
        s.sticks.yaw   = rand_stick(stick_span, wild);
        s.attitude.roll_angle  = 16'(rand_span(2000));
        s.attitude.pitch_angle = 16'(rand_span(2000));
        s.attitude.roll_rate   = 16'(rand_span(rate_span));
        s.attitude.pitch_rate  = 16'(rand_span(rate_span));
        s.attitude.yaw_rate    = 16'(rand_span(rate_span));
        return s;
    endfunction

    // Reference model: angle, P rate and quad-X mix rules in integer math
    function automatic motor_set_t expected_motor(input sample_t s);
        int         tgt [3];
        int         meas [3];
        int         corr [3];
        int         sum [4];
        int         thr;
        int         i;
        motor_set_t m;
        thr     = int'(s.sticks.throttle);
        tgt[0]  = (int'(s.sticks.roll) - `STICK_NEUTRAL) * (1 << `RATE_SHIFT);
        tgt[1]  = (int'(s.sticks.pitch) - `STICK_NEUTRAL) * (1 << `RATE_SHIFT);
        tgt[2]  = (int'(s.sticks.yaw) - `STICK_NEUTRAL) * (1 << `RATE_SHIFT);
        if (s.mode == MODE_ANGLE) begin
            tgt[0] = (int'(s.sticks.roll) - `STICK_NEUTRAL) * (1 << `ANGLE_SHIFT)
                     - int'(s.attitude.roll_angle);
            tgt[1] = (int'(s.sticks.pitch) - `STICK_NEUTRAL) * (1 << `ANGLE_SHIFT)
                     - int'(s.attitude.pitch_angle);
        end
        meas[0] = int'(s.attitude.roll_rate);
        meas[1] = int'(s.attitude.pitch_rate);
        meas[2] = int'(s.attitude.yaw_rate);
        for (i = 0; i < 3; i++) begin
            corr[i] = (tgt[i] - meas[i]) >>> `RATE_P_SHIFT;
            corr[i] = (corr[i] > `CORR_LIMIT) ? `CORR_LIMIT : corr[i];
            corr[i] = (corr[i] < -`CORR_LIMIT) ? -`CORR_LIMIT : corr[i];
        end
        sum[0] = thr + corr[0] + corr[1] - corr[2];
        sum[1] = thr - corr[0] + corr[1] + corr[2];
        sum[2] = thr - corr[0] - corr[1] - corr[2];
        sum[3] = thr + corr[0] - corr[1] + corr[2];
        for (i = 0; i < 4; i++) begin
            sum[i] = (sum[i] < 0 || thr < `ARM_THROTTLE) ? 0 : sum[i];
            sum[i] = (sum[i] > `MOTOR_MAX) ? `MOTOR_MAX : sum[i];
        end
        m = {8'(sum[0]), 8'(sum[1]), 8'(sum[2]), 8'(sum[3])};
        return m;
    endfunction

    task automatic check_motor(input motor_set_t got, input motor_set_t exp);
        if (got !== exp) begin
            $display("[ERROR] motor: got 0x%h expected 0x%h", got, exp);
            errors++;
        end
    endtask

    // High cycles per channel against rate times tick length
    task automatic check_pwm(input int unsigned high [4], input motor_set_t rates);
        logic [7:0] r [4];
        int         i;
        r = '{rates.motor_1, rates.motor_2, rates.motor_3, rates.motor_4};
        for (i = 0; i < 4; i++) begin
            if (high[i] != r[i] * `PWM_TICK_DIV) begin
                $display("[ERROR] motor_pwm_out[%0d]: got 0x%h high cycles expected 0x%h",
                         i, high[i], r[i] * `PWM_TICK_DIV);
                errors++;
            end
        end
    endtask

    // Expected values enter at the cycle the DUT takes the sample
    always @(posedge sys_clk) begin
        if (resetn && sample_valid) begin
            exp_q.push_back(expected_motor(sample));
            stamp_q.push_back(cycle);
        end
    end

    always @(posedge sys_clk) begin : compare_results
        int latency;
        if (resetn && motor_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("Motor result arrived with no sample outstanding");
                errors++;
            end else begin
                check_motor(motor, exp_q.pop_front());
                latency = cycle - stamp_q.pop_front();
                if (latency != 5) begin
                    $display("Motor result came %0d cycles after its sample, not 5", latency);
                    errors++;
                end
            end
        end
    end

    task automatic send_sample(input sample_t s);
        @(posedge sys_clk);
        sample       <= s;
        sample_valid <= 1'b1;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge sys_clk);
            sample_valid <= 1'b0;
        end
    endtask

    task automatic report_test(input string name, input int count, input int err_start);
        // Let every outstanding result come back first
        while (exp_q.size() != 0) @(posedge sys_clk);
        if (errors == err_start) begin
            passed++;
            $display("%s: %0d samples, ok", name, count);
        end else begin
            failed++;
            $display("%s: %0d samples, %0d errors", name, count, errors - err_start);
        end
    endtask

    task automatic run_batch(input string name, input sample_kind_e kind, input int count,
                             input int gap);
        int err_start;
        err_start = errors;
        repeat (count) begin
            send_sample(make_sample(kind));
            idle(gap);
        end
        idle(1);
        report_test(name, count, err_start);
    endtask

    // Rates 80, 20, 0, 60 from throttle 40 and roll and pitch rate errors
    task automatic run_pwm_test();
        sample_t     s;
        motor_set_t  rates;
        int unsigned high [4];
        int          err_start;
        int          i;
        err_start = errors;
        s = '0;
        s.mode = MODE_RATE;
        s.sticks = {8'd40, 8'(`STICK_NEUTRAL), 8'(`STICK_NEUTRAL), 8'(`STICK_NEUTRAL)};
        s.attitude.roll_rate  = -16'sd480;
        s.attitude.pitch_rate = -16'sd160;
        rates = expected_motor(s);
        send_sample(s);
        // Second edge so the sample is already queued
        idle(2);
        while (exp_q.size() != 0) @(posedge sys_clk);
        // One frame so the new set is active, then count over one full period
        repeat (FRAME_CYCLES) @(posedge sys_clk);
        high = '{default: 0};
        repeat (FRAME_CYCLES) begin
            @(posedge sys_clk);
            for (i = 0; i < 4; i++) begin
                high[i] += motor_pwm_out[i];
            end
        end
        check_pwm(high, rates);
        report_test("pwm", 1, err_start);
    endtask

    initial begin
        repeat (4) @(posedge sys_clk);
        resetn <= 1'b1;
        run_batch("rate_mode", KIND_RATE, N_RATE, 6);
        run_batch("angle_mode", KIND_ANGLE, N_ANGLE, 6);
        run_batch("saturation", KIND_SAT, N_SAT, 3);
        run_batch("disarm", KIND_DISARM, N_DISARM, 3);
        run_batch("streaming", KIND_STREAM, N_STREAM, 0);
        run_pwm_test();
        $display("Tests: %0d passed, %0d failed, %0d errors", passed, failed, errors);
        if (errors == 0 && failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Bounded by the sample count and the PWM frames
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
        $display("Run did not finish within %0d cycles, %0d results outstanding",
                 WATCHDOG_CYCLES, exp_q.size());
        $display("Some tests failed");
        $finish;
    end

endmodule
